/* verilog.f */
+incdir+rtl
rtl/osd_ctrl_pkg.sv
rtl/reg_bus_if.sv
rtl/osd_char_ram.sv
rtl/lockloss_counter.sv
rtl/i2c_target.sv
rtl/osd_reg_file.sv
rtl/osd_ctrl_top.sv
test/osd_ctrl_tb.sv

/* test/osd_ctrl_tb.sv */
// drives osd_ctrl_top through a bit-banged I2C master on scl and sda_in
// sda is modelled as a wired-AND of master drive and sda_drive_low
// scl phases of 8 clocks each against the 4-clock minimum
`include "osd_ctrl_defines.svh"

module osd_ctrl_tb;

    logic        clk = 1'b0;
    logic        reset;
    logic        scl;
    logic        sda_m;
    logic        sda_in;
    logic        sda_drive_low;
    logic [3:0]  locks;
    logic [3:0]  video_status;
    logic [9:0]  osd_rd_addr;
    logic [7:0]  osd_rd_data;
    logic        enable_osd;
    logic [7:0]  highlight_line;
    logic [8:0]  scan_intensity;
    logic        scan_thickness;
    logic        scan_oddeven;
    logic        scan_active;
    logic        reset_dc;

    int          errors = 0;
    int          dc_cycles;
    logic        foreign_xfer = 1'b0;
    logic [31:0] lfsr = 32'hd2061dfc;
    logic [7:0]  wr_buf [0:15];
    logic [7:0]  rd_buf [0:15];

    osd_ctrl_top UUT (
        .clk            (clk),
        .reset          (reset),
        .scl            (scl),
        .sda_in         (sda_in),
        .sda_drive_low  (sda_drive_low),
        .locks          (locks),
        .video_status   (video_status),
        .osd_rd_addr    (osd_rd_addr),
        .osd_rd_data    (osd_rd_data),
        .enable_osd     (enable_osd),
        .highlight_line (highlight_line),
        .scan_intensity (scan_intensity),
        .scan_thickness (scan_thickness),
        .scan_oddeven   (scan_oddeven),
        .scan_active    (scan_active),
        .reset_dc       (reset_dc)
    );

    always #10 clk = ~clk;

    // open-drain bus where the target can only pull low
    assign sda_in = sda_m & ~(sda_drive_low === 1'b1);

    // cycles that reset_dc spent high
    always @(posedge clk) begin
        if (reset)
            dc_cycles <= 0;
        else if (reset_dc)
            dc_cycles <= dc_cycles + 1;
    end

    ////////////////////////////////////////
    // concurrent checks
    ////////////////////////////////////////
    assert property (@(posedge clk) disable iff (reset) reset_dc |=> !reset_dc)
    else begin
        errors++;
        $display("reset_dc stayed high for two cycles in a row");
    end

    // no ack and no read data toward a foreign address
    assert property (@(posedge clk) foreign_xfer |-> !sda_drive_low)
    else begin
        errors++;
        $display("target pulled sda low during a foreign-address transfer");
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    // taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < nbits; k++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_ack(input logic acked, input string what);
        assert (acked)
        else begin
            errors++;
            $display("target did not acknowledge the %s", what);
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    ////////////////////////////////////////
    // I2C master
    ////////////////////////////////////////
    // also serves as repeated start with scl low on entry
    task automatic i2c_start();
        sda_m = 1'b1;
        wait_clocks(4);
        scl = 1'b1;
        wait_clocks(8);
        sda_m = 1'b0;
        wait_clocks(8);
        scl = 1'b0;
        wait_clocks(4);
    endtask

    task automatic i2c_stop();
        sda_m = 1'b0;
        wait_clocks(4);
        scl = 1'b1;
        wait_clocks(8);
        sda_m = 1'b1;
        wait_clocks(8);
    endtask

    // data set mid low phase and held 8 clocks high
    task automatic write_bit(input logic b);
        sda_m = b;
        wait_clocks(4);
        scl = 1'b1;
        wait_clocks(8);
        scl = 1'b0;
        wait_clocks(4);
    endtask

    task automatic read_bit(output logic b);
        sda_m = 1'b1;
        wait_clocks(4);
        scl = 1'b1;
        wait_clocks(4);
        b = sda_in;
        wait_clocks(4);
        scl = 1'b0;
        wait_clocks(4);
    endtask

    task automatic send_byte(input logic [7:0] data, output logic acked);
        acked = 1'b0;
        for (int k = 7; k >= 0; k--)
            write_bit(data[k]);
        sda_m = 1'b1;
        wait_clocks(4);
        scl = 1'b1;
        // ack poll bounded by the high phase
        for (int t = 0; t < 8; t++) begin
            @(negedge clk);
            if (!sda_in)
                acked = 1'b1;
        end
        scl = 1'b0;
        wait_clocks(4);
    endtask

    task automatic recv_byte(output logic [7:0] data, input logic ack);
        logic b;
        for (int k = 7; k >= 0; k--) begin
            read_bit(b);
            data[k] = b;
        end
        write_bit(~ack);
    endtask

    // pointer byte then n bytes from wr_buf
    task automatic reg_write(input logic [7:0] ptr, input int n);
        logic a;
        i2c_start();
        send_byte({`OSD_I2C_ADDR, 1'b0}, a);
        check_ack(a, "write address");
        send_byte(ptr, a);
        check_ack(a, "pointer byte");
        for (int i = 0; i < n; i++) begin
            send_byte(wr_buf[i], a);
            check_ack(a, "data byte");
        end
        i2c_stop();
    endtask

    // pointer write then repeated start and n bytes into rd_buf
    task automatic reg_read(input logic [7:0] ptr, input int n);
        logic a;
        i2c_start();
        send_byte({`OSD_I2C_ADDR, 1'b0}, a);
        check_ack(a, "write address");
        send_byte(ptr, a);
        check_ack(a, "pointer byte");
        i2c_start();
        send_byte({`OSD_I2C_ADDR, 1'b1}, a);
        check_ack(a, "read address");
        for (int i = 0; i < n; i++)
            recv_byte(rd_buf[i], i != n - 1);
        i2c_stop();
    endtask

    task automatic drop_lock(input int idx, input int times);
        for (int k = 0; k < times; k++) begin
            locks[idx] = 1'b0;
            wait_clocks(4);
            locks[idx] = 1'b1;
            wait_clocks(4);
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial begin
        logic [31:0] v;
        logic [7:0]  d81;
        logic [7:0]  d82;
        logic [7:0]  d88;
        logic [7:0]  d89;
        logic [7:0]  d89_inv;
        logic [7:0]  ram_exp [0:5];
        logic [31:0] cnt_exp [0:3];
        logic [21:0] snap;
        logic        a;
        reset        = 1'b1;
        scl          = 1'b1;
        sda_m        = 1'b1;
        locks        = 4'hF;
        video_status = 4'h0;
        osd_rd_addr  = '0;
        wait_clocks(3);
        reset = 1'b0;
        wait_clocks(2);

        // reset values
        check_value("enable_osd", enable_osd, 0);
        check_value("highlight_line", highlight_line, 8'hFF);
        check_value("scan_intensity", scan_intensity, 9'h100);
        check_value("scan_flags", {scan_thickness, scan_oddeven, scan_active}, 0);

        // settings 0x81 to 0x89 with 0x83 to 0x87 ignored
        for (int i = 0; i < 9; i++) begin
            draw_bits(8, v);
            wr_buf[i] = v[7:0];
        end
        // enable forced on to leave its reset value
        wr_buf[0][0] = 1'b1;
        d81 = wr_buf[0];
        d82 = wr_buf[1];
        d88 = wr_buf[7];
        d89 = wr_buf[8];
        reg_write(`REG_OSD_ENABLE, 9);
        check_value("enable_osd", enable_osd, d81[0]);
        check_value("highlight_line", highlight_line, d82);
        check_value("scan_intensity", scan_intensity, {d88, d89[7]});
        check_value("scan_thickness", scan_thickness, d89[6]);
        check_value("scan_oddeven", scan_oddeven, d89[5]);
        check_value("scan_active", scan_active, d89[4]);
        reg_read(`REG_SCAN_HI, 2);
        check_value("rdata 0x88", rd_buf[0], d88);
        check_value("rdata 0x89", rd_buf[1], {d89[7:4], 4'h0});
        draw_bits(4, v);
        video_status = v[3:0];
        reg_read(`REG_STATUS, 1);
        check_value("rdata 0x87", rd_buf[0], {v[3:0], d81[0], 3'b000});

        // second 0x89 write flips every flag
        d89_inv   = ~d89;
        wr_buf[0] = d89_inv;
        reg_write(`REG_SCAN_LO, 1);
        check_value("scan_intensity", scan_intensity, {d88, d89_inv[7]});
        check_value("scan_thickness", scan_thickness, d89_inv[6]);
        check_value("scan_oddeven", scan_oddeven, d89_inv[5]);
        check_value("scan_active", scan_active, d89_inv[4]);

        // osd ram page 5 from pointer 0x10
        wr_buf[0] = 8'd5;
        reg_write(`REG_OSD_PAGE, 1);
        for (int i = 0; i < 6; i++) begin
            draw_bits(8, v);
            wr_buf[i]  = v[7:0];
            ram_exp[i] = v[7:0];
        end
        reg_write(8'h10, 6);
        for (int i = 0; i < 6; i++) begin
            osd_rd_addr = {3'd5, 7'h10} + i;
            wait_clocks(1);
            check_value("osd_rd_data", osd_rd_data, ram_exp[i]);
        end

        // lock-loss counters with a different count per input
        cnt_exp[0] = 2;
        cnt_exp[1] = 5;
        cnt_exp[2] = 1;
        cnt_exp[3] = 3;
        for (int c = 0; c < 4; c++)
            drop_lock(c, cnt_exp[c]);
        wait_clocks(4);
        reg_read(`REG_CNT_BASE, 16);
        for (int i = 0; i < 16; i++)
            check_value("counter byte", rd_buf[i],
                        cnt_exp[i / 4] >> (8 * (3 - i % 4)) & 8'hFF);
        wr_buf[0] = 8'h01;
        reg_write(`REG_CNT_CLEAR, 1);
        reg_read(`REG_CNT_BASE, 16);
        for (int i = 0; i < 16; i++)
            check_value("cleared counter byte", rd_buf[i], 0);

        // console reset pulse
        check_value("reset_dc cycles", dc_cycles, 0);
        reg_write(`REG_RESET_DC, 1);
        check_value("reset_dc cycles", dc_cycles, 1);

        // foreign address must leave every output alone
        snap = {enable_osd, highlight_line, scan_intensity, scan_thickness,
                scan_oddeven, scan_active, reset_dc};
        foreign_xfer = 1'b1;
        i2c_start();
        send_byte({7'h5A, 1'b0}, a);
        check_value("foreign address ack", a, 0);
        send_byte(`REG_OSD_ENABLE, a);
        // would clear enable if accepted
        send_byte(8'h00, a);
        i2c_stop();
        foreign_xfer = 1'b0;
        check_value("outputs after foreign transfer",
                    {enable_osd, highlight_line, scan_intensity, scan_thickness,
                     scan_oddeven, scan_active, reset_dc}, snap);
        check_value("reset_dc cycles", dc_cycles, 1);

        wait_clocks(4);
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* rtl/osd_ctrl_top.sv */
// OSD control top: I2C target, register map, char RAM, lock counters
// sda_drive_low drives an open-drain pad outside this block
// locks are asynchronous; order adv pll, hpd, 54 MHz pll, hdmi pll
`include "osd_ctrl_defines.svh"

module osd_ctrl_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   scl,
    input  logic                   sda_in,
    output logic                   sda_drive_low,
    input  logic [3:0]             locks,
    input  logic [3:0]             video_status,
    input  logic [`OSD_RAM_AW-1:0] osd_rd_addr,
    output logic [7:0]             osd_rd_data,
    output logic                   enable_osd,
    output logic [7:0]             highlight_line,
    output logic [8:0]             scan_intensity,
    output logic                   scan_thickness,
    output logic                   scan_oddeven,
    output logic                   scan_active,
    output logic                   reset_dc
);

    reg_bus_if bus ();

    logic                        ram_we;
    logic [`OSD_RAM_AW-1:0]      ram_waddr;
    logic [7:0]                  ram_wdata;
    logic                        cnt_clear;
    osd_ctrl_pkg::lock_cnt_t     lock_cnt;
    osd_ctrl_pkg::scanline_cfg_t scanline;

    i2c_target u_i2c (
        .clk           (clk),
        .reset         (reset),
        .scl           (scl),
        .sda_in        (sda_in),
        .sda_drive_low (sda_drive_low),
        .bus           (bus.target)
    );

    osd_reg_file u_regs (
        .clk            (clk),
        .reset          (reset),
        .bus            (bus.regs),
        .video_status   (video_status),
        .lock_cnt       (lock_cnt),
        .ram_we         (ram_we),
        .ram_waddr      (ram_waddr),
        .ram_wdata      (ram_wdata),
        .cnt_clear      (cnt_clear),
        .enable_osd     (enable_osd),
        .highlight_line (highlight_line),
        .scanline       (scanline),
        .reset_dc       (reset_dc)
    );

    // renderer reads through the second port
    osd_char_ram u_ram (
        .clk     (clk),
        .we      (ram_we),
        .waddr   (ram_waddr),
        .wdata   (ram_wdata),
        .rd_addr (osd_rd_addr),
        .rd_data (osd_rd_data)
    );

    // one counter per lock input
    for (genvar i = 0; i < 4; i++) begin : g_lock
        lockloss_counter u_cnt (
            .clk   (clk),
            .reset (reset),
            .lock  (locks[i]),
            .clear (cnt_clear),
            .count (lock_cnt[i])
        );
    end

    // flatten scanline settings
    assign scan_intensity = scanline.intensity;
    assign scan_thickness = scanline.thickness;
    assign scan_oddeven   = scanline.oddeven;
    assign scan_active    = scanline.active;

endmodule

/* rtl/osd_reg_file.sv */
// register map of the OSD control target
// writes act on the we clock, strobes follow one clock later
// rdata is registered, undefined pointers read 0
`include "osd_ctrl_defines.svh"

module osd_reg_file (
    input  logic                        clk,
    input  logic                        reset,
    reg_bus_if.regs                     bus,
    input  logic [3:0]                  video_status,
    input  osd_ctrl_pkg::lock_cnt_t     lock_cnt,
    output logic                        ram_we,
    output logic [`OSD_RAM_AW-1:0]      ram_waddr,
    output logic [7:0]                  ram_wdata,
    output logic                        cnt_clear,
    output logic                        enable_osd,
    output logic [7:0]                  highlight_line,
    output osd_ctrl_pkg::scanline_cfg_t scanline,
    output logic                        reset_dc
);

    // osd ram page, upper address bits
    logic [2:0]             page;
    logic [`LOCK_CNT_W-1:0] cnt_word;

    ////////////////////////////////////////
    // write decode
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            page                <= '0;
            enable_osd          <= 1'b0;
            highlight_line      <= 8'hFF;
            scanline.intensity  <= 9'h100;
            scanline.thickness  <= 1'b0;
            scanline.oddeven    <= 1'b0;
            scanline.active     <= 1'b0;
            ram_we              <= 1'b0;
            reset_dc            <= 1'b0;
            cnt_clear           <= 1'b0;
        end else begin
            // single-cycle strobes
            ram_we    <= 1'b0;
            reset_dc  <= 1'b0;
            cnt_clear <= 1'b0;
            if (bus.we) begin
                if (bus.addr < `REG_OSD_PAGE) begin
                    ram_we <= 1'b1;
                end else begin
                    case (bus.addr)
                        `REG_OSD_PAGE:   page           <= bus.wdata[2:0];
                        `REG_OSD_ENABLE: enable_osd     <= bus.wdata[0];
                        `REG_HIGHLIGHT:  highlight_line <= bus.wdata;
                        `REG_SCAN_HI:    scanline.intensity[8:1] <= bus.wdata;
                        // intensity lsb then the three flags
                        `REG_SCAN_LO: begin
                            scanline.intensity[0] <= bus.wdata[7];
                            scanline.thickness    <= bus.wdata[6];
                            scanline.oddeven      <= bus.wdata[5];
                            scanline.active       <= bus.wdata[4];
                        end
                        `REG_RESET_DC:   reset_dc  <= 1'b1;
                        `REG_CNT_CLEAR:  cnt_clear <= 1'b1;
                        default: ;
                    endcase
                end
            end
        end
    end

    // ram write address and data, aligned with ram_we
    always_ff @(posedge clk) begin
        if (bus.we) begin
            ram_waddr <= {page, bus.addr[6:0]};
            ram_wdata <= bus.wdata;
        end
    end

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////
    // counter picked by pointer bits 3:2
    assign cnt_word = lock_cnt[bus.addr[3:2]];

    always_ff @(posedge clk) begin
        if ((bus.addr & 8'hF0) == `REG_CNT_BASE) begin
            // most significant byte at the lowest pointer
            bus.rdata <= cnt_word[`LOCK_CNT_W-1 - 8*bus.addr[1:0] -: 8];
        end else begin
            case (bus.addr)
                `REG_OSD_PAGE:   bus.rdata <= {5'd0, page};
                `REG_OSD_ENABLE: bus.rdata <= {7'd0, enable_osd};
                `REG_HIGHLIGHT:  bus.rdata <= highlight_line;
                // status, video flags over osd enable
                `REG_STATUS:     bus.rdata <= {video_status, enable_osd, 3'b000};
                `REG_SCAN_HI:    bus.rdata <= scanline.intensity[8:1];
                `REG_SCAN_LO: begin
                    bus.rdata <= {scanline.intensity[0], scanline.thickness,
                                  scanline.oddeven, scanline.active, 4'b0000};
                end
                default:         bus.rdata <= 8'h00;
            endcase
        end
    end

endmodule

/* rtl/i2c_target.sv */
// byte-level I2C target, 7-bit addressing, no clock stretching
// scl must stay low and high at least 4 clk each
// first write byte sets the pointer, later bytes write and auto-increment
`include "osd_ctrl_defines.svh"

module i2c_target (
    input  logic      clk,
    input  logic      reset,
    input  logic      scl,
    input  logic      sda_in,
    output logic      sda_drive_low,
    reg_bus_if.target bus
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_ADDR_ACK,
        ST_WR_BYTE,
        ST_WR_ACK,
        ST_RD_BYTE,
        ST_RD_ACK
    } state_t;

    state_t     state;
    logic [1:0] scl_sync;
    logic [1:0] sda_sync;
    logic       scl_prev;
    logic       sda_prev;
    logic       scl_s;
    logic       sda_s;
    logic       scl_rise;
    logic       scl_fall;
    logic       start_det;
    logic       stop_det;
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic [7:0] rx_byte;
    logic [7:0] ptr;
    logic       rd_mode;
    logic       first_byte;
    logic       nack;

    ////////////////////////////////////////
    // synchronizers and bus conditions
    ////////////////////////////////////////
    // idle bus is high, so reset to 1 to avoid a false start
    always_ff @(posedge clk) begin
        if (reset) begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[0], scl};
            sda_sync <= {sda_sync[0], sda_in};
            scl_prev <= scl_s;
            sda_prev <= sda_s;
        end
    end

    assign scl_s     = scl_sync[1];
    assign sda_s     = sda_sync[1];
    assign scl_rise  = scl_s & ~scl_prev;
    assign scl_fall  = ~scl_s & scl_prev;
    // sda moving while scl high
    assign start_det = scl_s & scl_prev & sda_prev & ~sda_s;
    assign stop_det  = scl_s & scl_prev & ~sda_prev & sda_s;
    // byte including the bit sampled on this rise
    assign rx_byte   = {shreg[6:0], sda_s};
    assign bus.addr  = ptr;

    ////////////////////////////////////////
    // bit and byte FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_IDLE;
            bit_cnt       <= '0;
            shreg         <= '0;
            ptr           <= '0;
            rd_mode       <= 1'b0;
            first_byte    <= 1'b0;
            nack          <= 1'b0;
            sda_drive_low <= 1'b0;
            bus.we        <= 1'b0;
            bus.wdata     <= '0;
        end else begin
            bus.we <= 1'b0;
            // pointer steps once the write strobe is seen
            if (bus.we)
                ptr <= ptr + 8'd1;
            if (start_det) begin
                // start or repeated start, from any state
                state         <= ST_ADDR;
                bit_cnt       <= '0;
                first_byte    <= 1'b1;
                sda_drive_low <= 1'b0;
            end else if (stop_det) begin
                state         <= ST_IDLE;
                sda_drive_low <= 1'b0;
            end else if (scl_rise) begin
                case (state)
                    ST_ADDR, ST_WR_BYTE: begin
                        shreg   <= rx_byte;
                        bit_cnt <= bit_cnt + 4'd1;
                        // 8th data bit completes a write byte
                        if (state == ST_WR_BYTE && bit_cnt == 4'd7) begin
                            if (first_byte) begin
                                ptr        <= rx_byte;
                                first_byte <= 1'b0;
                            end else begin
                                bus.we    <= 1'b1;
                                bus.wdata <= rx_byte;
                            end
                        end
                    end
                    ST_RD_BYTE: bit_cnt <= bit_cnt + 4'd1;
                    // master ack bit, high means nack
                    ST_RD_ACK: begin
                        nack <= sda_s;
                        ptr  <= ptr + 8'd1;
                    end
                    default: ;
                endcase
            end else if (scl_fall) begin
                case (state)
                    ST_ADDR: begin
                        if (bit_cnt == 4'd8) begin
                            // foreign address, stay off the bus
                            if (shreg[7:1] == `OSD_I2C_ADDR) begin
                                state         <= ST_ADDR_ACK;
                                rd_mode       <= shreg[0];
                                sda_drive_low <= 1'b1;
                            end else begin
                                state <= ST_IDLE;
                            end
                        end
                    end
                    ST_ADDR_ACK: begin
                        bit_cnt <= '0;
                        if (rd_mode) begin
                            state         <= ST_RD_BYTE;
                            shreg         <= bus.rdata;
                            sda_drive_low <= ~bus.rdata[7];
                        end else begin
                            state         <= ST_WR_BYTE;
                            sda_drive_low <= 1'b0;
                        end
                    end
                    ST_WR_BYTE: begin
                        if (bit_cnt == 4'd8) begin
                            state         <= ST_WR_ACK;
                            sda_drive_low <= 1'b1;
                        end
                    end
                    ST_WR_ACK: begin
                        state         <= ST_WR_BYTE;
                        bit_cnt       <= '0;
                        sda_drive_low <= 1'b0;
                    end
                    ST_RD_BYTE: begin
                        if (bit_cnt == 4'd8) begin
                            // release for the master ack
                            state         <= ST_RD_ACK;
                            sda_drive_low <= 1'b0;
                        end else begin
                            shreg         <= {shreg[6:0], 1'b0};
                            sda_drive_low <= ~shreg[6];
                        end
                    end
                    ST_RD_ACK: begin
                        if (nack) begin
                            state <= ST_IDLE;
                        end else begin
                            // rdata has settled since the ack rise
                            state         <= ST_RD_BYTE;
                            bit_cnt       <= '0;
                            shreg         <= bus.rdata;
                            sda_drive_low <= ~bus.rdata[7];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* rtl/lockloss_counter.sv */
// counts falling edges of an asynchronous lock level
// saturates at all ones, clear wins over an edge
`include "osd_ctrl_defines.svh"

module lockloss_counter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   lock,
    input  logic                   clear,
    output logic [`LOCK_CNT_W-1:0] count
);

    logic [1:0] lock_sync;
    logic       lock_prev;
    logic       lock_fall;

    // 2-flop sync, then edge history
    always_ff @(posedge clk) begin
        if (reset) begin
            lock_sync <= 2'b00;
            lock_prev <= 1'b0;
        end else begin
            lock_sync <= {lock_sync[0], lock};
            lock_prev <= lock_sync[1];
        end
    end

    assign lock_fall = lock_prev & ~lock_sync[1];

    always_ff @(posedge clk) begin
        if (reset || clear)
            count <= '0;
        else if (lock_fall && count != '1)
            count <= count + 1'b1;
    end

endmodule

/* rtl/osd_char_ram.sv */
// OSD character RAM, one write port and one registered read port
// contents are not cleared by reset
`include "osd_ctrl_defines.svh"

module osd_char_ram (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`OSD_RAM_AW-1:0] waddr,
    input  logic [7:0]             wdata,
    input  logic [`OSD_RAM_AW-1:0] rd_addr,
    output logic [7:0]             rd_data
);

    // 8 pages of 128 characters
    logic [7:0] mem [0:(1 << `OSD_RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // renderer side, one clock latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/reg_bus_if.sv */
// byte-wide register bus between the I2C target and the register file
// no handshake; we is a single-cycle strobe
// rdata is registered and follows addr one clock later
interface reg_bus_if;

    // register pointer, held for whole bytes
    logic [7:0] addr;
    logic [7:0] wdata;
    logic       we;
    // read data, one clock behind addr
    logic [7:0] rdata;

    modport target (
        output addr, wdata, we,
        input  rdata
    );

    modport regs (
        input  addr, wdata, we,
        output rdata
    );

endinterface

/* rtl/osd_ctrl_pkg.sv */
// shared types of the OSD control block
// lock_cnt_t index order is fixed by the counter register map
`include "osd_ctrl_defines.svh"

package osd_ctrl_pkg;

    // scanline settings, packed msb first
    typedef struct packed {
        logic [8:0] intensity;
        logic       thickness;
        logic       oddeven;
        logic       active;
    } scanline_cfg_t;

    // four lock-loss counters
    // 0 adv pll
    // 1 hdmi hot-plug
    // 2 54 MHz pll
    // 3 hdmi pll
    typedef logic [3:0][`LOCK_CNT_W-1:0] lock_cnt_t;

endpackage

/* rtl/osd_ctrl_defines.svh */
// device address, register map and sizes for the OSD control target
// register values are 8-bit pointers as seen on the I2C bus
// counter width is fixed at 32 because the map reads 4 bytes per counter
`ifndef OSD_CTRL_DEFINES_SVH
`define OSD_CTRL_DEFINES_SVH

// 7-bit I2C device address
`define OSD_I2C_ADDR    7'h3C

// osd ram address, 3-bit page + 7-bit pointer
`define OSD_RAM_AW      10

// register map
`define REG_OSD_PAGE    8'h80
`define REG_OSD_ENABLE  8'h81
`define REG_HIGHLIGHT   8'h82
`define REG_STATUS      8'h87
`define REG_SCAN_HI     8'h88
`define REG_SCAN_LO     8'h89
`define REG_CNT_BASE    8'hA0
`define REG_RESET_DC    8'hF0
`define REG_CNT_CLEAR   8'hF2

`define LOCK_CNT_W      32

`endif
